//--- source/pce_input_pkg.sv
package pce_input_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes and constants
	//////////////////////////////////////////////////////////////////////

	// Ports behind the multitap
	localparam int NUM_PORTS = 5;
	localparam int PORT_W = 3;

	// Saturates after 32767 cycles with CLR low
	localparam int MOUSE_IDLE_W = 15;

	// Port numbers past the last pad read as nothing pressed
	localparam logic [15:0] EMPTY_PAD_WORD = 16'h0FFF;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// Host joystick, active high, right in bit 0
	typedef struct packed {
		logic button_vi;
		logic button_v;
		logic button_iv;
		logic button_iii;
		logic run;
		logic select;
		logic button_ii;
		logic button_i;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// Console pad word, active low, one nibble per read
	typedef struct packed {
		logic [3:0] ident;
		logic [3:0] extra_buttons;
		logic [3:0] directions;
		logic [3:0] buttons;
	} pad_word_t;

	// Host mouse report, strobe toggles once per report
	typedef struct packed {
		logic       strobe;
		logic [7:0] dy;
		logic [7:0] dx;
		logic       btn_right;
		logic       btn_left;
	} mouse_report_t;

	// Lines driven by the console
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctrl_t;

	typedef struct packed {
		logic tap_en;
		logic six_btn_en;
		logic mouse_en;
	} input_mode_t;

endpackage

//--- source/pad_mux.sv
`timescale 1ns/1ns

module pad_mux import pce_input_pkg::*; (
	input  joy_t              joy [NUM_PORTS],
	input  logic [PORT_W-1:0] port,
	input  logic              mouse_en,
	input  logic [1:0]        mouse_buttons,
	input  logic [3:0]        mouse_nibble,
	output pad_word_t         word
);

	logic [7:0] mouse_byte;

	// Host joystick to console pad word
	function automatic pad_word_t encode_pad(input joy_t j);
		pad_word_t w;
		w.ident = 4'h0;
		w.extra_buttons = ~{j.button_vi, j.button_v, j.button_iv, j.button_iii};
		w.directions = ~{j.left, j.down, j.right, j.up};
		w.buttons = ~{j.run, j.select, j.button_ii, j.button_i};
		return w;
	endfunction

	// Movement nibble on top, buttons below
	assign mouse_byte = {mouse_nibble, ~{2'b00, mouse_buttons}};

	//////////////////////////////////////////////////////////////////////
	// Port select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		word = pad_word_t'(EMPTY_PAD_WORD);
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (port == PORT_W'(i)) begin
				word = encode_pad(joy[i]);
			end
		end

		// Mouse takes over port 0, same byte for either bank
		if (mouse_en && port == '0) begin
			word = pad_word_t'({mouse_byte, mouse_byte});
		end
	end

endmodule

//--- source/mouse_sampler.sv
`timescale 1ns/1ns

module mouse_sampler import pce_input_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  mouse_report_t mouse,
	input  logic          clr,
	input  logic          clr_rise,
	output logic [3:0]    mouse_nibble
);

	logic                    strobe_q;
	logic                    new_report;
	logic [MOUSE_IDLE_W-1:0] idle_cnt;
	logic                    idle_full;
	logic [1:0]              count;

	// Movement since the last snapshot
	logic [7:0] acc_x;
	logic [7:0] acc_y;

	// Values the console is reading out
	logic [7:0] snap_x;
	logic [7:0] snap_y;

	assign new_report = mouse.strobe ^ strobe_q;
	assign idle_full = &idle_cnt;

	//////////////////////////////////////////////////////////////////////
	// Idle timeout
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (clr) begin
			idle_cnt <= '0;
		end else if (!idle_full) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Report capture and nibble sequence
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= 1'b0;
			count <= 2'd3;
			acc_x <= '0;
			acc_y <= '0;
			snap_x <= '0;
			snap_y <= '0;
		end else begin
			strobe_q <= mouse.strobe;

			// Console gave up mid sequence, restart on next read
			if (idle_full) begin
				count <= 2'd3;
			end

			if (clr_rise) begin
				count <= count + 2'd1;
				if (&count) begin
					snap_x <= acc_x;
					snap_y <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// A fresh report wins over the clear on wrap
			// X runs the other way on the console
			if (new_report) begin
				acc_x <= 8'd0 - mouse.dx;
				acc_y <= mouse.dy;
			end
		end
	end

	always_comb begin
		case (count)
			2'd0: mouse_nibble = snap_x[7:4];
			2'd1: mouse_nibble = snap_x[3:0];
			2'd2: mouse_nibble = snap_y[7:4];
			default: mouse_nibble = snap_y[3:0];
		endcase
	end

	// Timeout must restart the sequence
	idle_resync: assert property (
		@(posedge clk_sys) disable iff (reset)
		idle_full |=> count == 2'd3
	);

endmodule

//--- source/tap_scanner.sv
`timescale 1ns/1ns

module tap_scanner import pce_input_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  port_ctrl_t        ctrl,
	input  input_mode_t       mode,
	input  pad_word_t         word,
	output logic [PORT_W-1:0] port,
	output logic              high_bank,
	output logic              clr_rise,
	output logic [3:0]        nibble
);

	port_ctrl_t  ctrl_q;
	logic        clr_edge;
	logic        sel_edge;
	logic [1:0]  nibble_idx;
	logic [15:0] word_bits;

	assign clr_edge = ctrl.clr & ~ctrl_q.clr;
	assign sel_edge = ctrl.sel & ~ctrl_q.sel;

	// Bank picks the upper byte, SEL the nibble in it
	assign nibble_idx = {high_bank, ctrl.sel};
	assign word_bits = word;

	//////////////////////////////////////////////////////////////////////
	// Edge tracking and port counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_q <= '0;
			clr_rise <= 1'b0;
			port <= '0;
			high_bank <= 1'b0;
			nibble <= '0;
		end else begin
			ctrl_q <= ctrl;
			clr_rise <= clr_edge;
			nibble <= word_bits[{nibble_idx, 2'b00} +: 4];

			if (ctrl.clr) begin
				port <= '0;
				nibble <= '0;
				// Six button pads swap banks on every CLR pulse
				if (clr_edge) begin
					high_bank <= ~high_bank & mode.six_btn_en;
				end
			end else if (sel_edge && mode.tap_en) begin
				port <= port + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Without the multitap SEL only flips nibbles
	port_hold: assert property (
		@(posedge clk_sys) disable iff (reset)
		(!ctrl.clr && !mode.tap_en) |=> $stable(port)
	);

	clr_blank: assert property (
		@(posedge clk_sys) disable iff (reset)
		ctrl.clr |=> nibble == 4'd0
	);

endmodule

//--- source/pce_input.sv
`timescale 1ns/1ns

module pce_input import pce_input_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  joy_t          joy [NUM_PORTS],
	input  mouse_report_t mouse,
	input  input_mode_t   mode,
	input  port_ctrl_t    ctrl,
	output logic [3:0]    nibble
);

	logic [PORT_W-1:0] port;
	logic              high_bank;
	logic              clr_rise;
	logic [3:0]        mouse_nibble;
	pad_word_t         word;

	// Scanner follows the console lines and latches the answer
	tap_scanner u_tap_scanner (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ctrl      (ctrl),
		.mode      (mode),
		.word      (word),
		.port      (port),
		.high_bank (high_bank),
		.clr_rise  (clr_rise),
		.nibble    (nibble)
	);

	pad_mux u_pad_mux (
		.joy           (joy),
		.port          (port),
		.mouse_en      (mode.mouse_en),
		.mouse_buttons ({mouse.btn_right, mouse.btn_left}),
		.mouse_nibble  (mouse_nibble),
		.word          (word)
	);

	mouse_sampler u_mouse_sampler (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mouse        (mouse),
		.clr          (ctrl.clr),
		.clr_rise     (clr_rise),
		.mouse_nibble (mouse_nibble)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// 10 ns period
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

//--- dv/pce_input_tb.sv
`timescale 1ns/1ns

module pce_input_tb import pce_input_pkg::*; ();

	logic          clk_sys;
	logic          reset;
	joy_t          joy [NUM_PORTS];
	mouse_report_t mouse;
	input_mode_t   mode;
	port_ctrl_t    ctrl;
	logic [3:0]    nibble;
	integer        seed;
	int            error_count;

	// Bank the DUT should be on after the CLR pulses so far
	logic bank;

	tb_clock u_tb_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	pce_input u_pce_input (
		.clk_sys (clk_sys),
		.reset   (reset),
		.joy     (joy),
		.mouse   (mouse),
		.mode    (mode),
		.ctrl    (ctrl),
		.nibble  (nibble)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] model_pad_word(input joy_t j);
		logic [3:0] extra;
		logic [3:0] dirs;
		logic [3:0] btns;
		extra = ~{j.button_vi, j.button_v, j.button_iv, j.button_iii};
		dirs = ~{j.left, j.down, j.right, j.up};
		btns = ~{j.run, j.select, j.button_ii, j.button_i};
		return {4'h0, extra, dirs, btns};
	endfunction

	function automatic logic [15:0] expected_word(input int p);
		if (p >= NUM_PORTS) begin
			return EMPTY_PAD_WORD;
		end
		return model_pad_word(joy[p]);
	endfunction

	function automatic logic [3:0] pick_nibble(input logic [15:0] w, input logic hi,
			input logic sel);
		case ({hi, sel})
			2'b00: return w[3:0];
			2'b01: return w[7:4];
			2'b10: return w[11:8];
			default: return w[15:12];
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [3:0] actual,
			input logic [3:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("Error: time %0t %s got %h expected %h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
	endtask

	// Three cycles, then sample away from the edge
	task automatic settle();
		wait_cycles(3);
		@(negedge clk_sys);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset && cycles < 100) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (reset) begin
			$display("Reset was never released");
			$display("Verification failed");
			$fatal(1, "Reset timeout");
		end
	endtask

	task automatic drive_ctrl(input logic clr, input logic sel);
		@(posedge clk_sys);
		if (clr && !ctrl.clr) begin
			bank = mode.six_btn_en ? ~bank : 1'b0;
		end
		ctrl.clr <= clr;
		ctrl.sel <= sel;
	endtask

	task automatic set_mode(input logic tap, input logic six, input logic mouse_on);
		@(posedge clk_sys);
		mode.tap_en <= tap;
		mode.six_btn_en <= six;
		mode.mouse_en <= mouse_on;
	endtask

	task automatic randomize_joys();
		logic [31:0] rnd;
		@(posedge clk_sys);
		for (int i = 0; i < NUM_PORTS; i++) begin
			rnd = $random(seed);
			joy[i] <= rnd[11:0];
		end
	endtask

	// CLR pulse that leaves port 0 selected with SEL high
	task automatic pulse_clr();
		drive_ctrl(1'b1, 1'b1);
		wait_cycles(3);
		drive_ctrl(1'b0, 1'b1);
		settle();
	endtask

	task automatic read_expect(input logic sel, input logic [3:0] expected, input string name);
		drive_ctrl(1'b0, sel);
		settle();
		check_value(name, nibble, expected);
	endtask

	task automatic read_port(input int p, input logic sel);
		read_expect(sel, pick_nibble(expected_word(p), bank, sel),
			$sformatf("nibble (port %0d, sel %0b)", p, sel));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	// SEL pulses without the multitap stay on port 0
	task automatic single_pad();
		set_mode(1'b0, 1'b0, 1'b0);
		randomize_joys();
		pulse_clr();
		for (int k = 0; k < 3; k++) begin
			read_port(0, 1'b1);
			read_port(0, 1'b0);
		end
	endtask

	task automatic multitap_scan();
		set_mode(1'b1, 1'b0, 1'b0);
		randomize_joys();
		pulse_clr();
		for (int p = 0; p <= NUM_PORTS; p++) begin
			read_port(p, 1'b1);
			read_port(p, 1'b0);
		end
	endtask

	task automatic six_button_bank();
		set_mode(1'b0, 1'b1, 1'b0);
		randomize_joys();
		for (int k = 0; k < 4; k++) begin
			pulse_clr();
			read_port(0, 1'b1);
			read_port(0, 1'b0);
		end
		// Bank stays low once the mode is off
		set_mode(1'b0, 1'b0, 1'b0);
		for (int k = 0; k < 2; k++) begin
			pulse_clr();
			read_port(0, 1'b1);
			read_port(0, 1'b0);
		end
	endtask

	task automatic clr_forcing();
		set_mode(1'b1, 1'b0, 1'b0);
		for (int k = 0; k < 4; k++) begin
			randomize_joys();
			drive_ctrl(1'b1, k[0]);
			settle();
			check_value("nibble (CLR high)", nibble, 4'h0);
		end
		drive_ctrl(1'b0, 1'b1);
		set_mode(1'b0, 1'b0, 1'b0);
	endtask

	task automatic mouse_sequence();
		logic [7:0] dx;
		logic [7:0] dy;
		logic [7:0] exp_x;
		logic [3:0] expect_seq [4];
		dx = 8'h3A;
		dy = 8'hC5;
		exp_x = ~dx + 8'd1;
		expect_seq[0] = exp_x[7:4];
		expect_seq[1] = exp_x[3:0];
		expect_seq[2] = dy[7:4];
		expect_seq[3] = dy[3:0];
		set_mode(1'b0, 1'b0, 1'b1);
		pulse_clr();
		@(posedge clk_sys);
		mouse.dx <= dx;
		mouse.dy <= dy;
		mouse.btn_left <= 1'b1;
		mouse.btn_right <= 1'b0;
		mouse.strobe <= ~mouse.strobe;
		// Long CLR low idle puts the sequence back at its start
		wait_cycles(32800);
		for (int k = 0; k < 4; k++) begin
			pulse_clr();
			read_expect(1'b1, expect_seq[k], $sformatf("nibble (mouse step %0d)", k));
			read_expect(1'b0, 4'b1110, "nibble (mouse buttons)");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		error_count = 0;
		seed = 32'h887b_9168;
		bank = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			joy[i] = '0;
		end
		mouse = '0;
		mode = '0;
		ctrl = '0;

		wait_reset_release();
		single_pad();
		multitap_scan();
		six_button_bank();
		clr_forcing();
		mouse_sequence();

		if (error_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1, "Checks failed");
		end
	end

endmodule

//--- pce_input.f
source/pce_input_pkg.sv
source/pad_mux.sv
source/mouse_sampler.sv
source/tap_scanner.sv
source/pce_input.sv
dv/tb_clock.sv
dv/pce_input_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pce_input_tb
FILELIST  ?= pce_input.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
